//--- verilog/fetch_pkg.sv
package fetch_pkg;

  // byte address on the instruction bus.
  typedef logic [31:0] addr_t;

  // one instruction word.
  typedef logic [31:0] inst_t;

  // byte offset bits inside a 32-bit word.
  localparam int unsigned WORD_OFF_W = 2;

  // fence.i: funct3 001, opcode MISC-MEM.
  localparam inst_t FENCE_I_INST = 32'h0000_100f;

  // fetch control states.
  typedef enum logic [1:0] {
    IDLE     = 2'd0,  // waiting for a pc from pc_gen.
    LOOKUP   = 2'd1,  // cache answer arrives this cycle.
    BUS_WAIT = 2'd2,  // miss, read request outstanding.
    HOLD     = 2'd3   // instruction presented to decode.
  } bus_state_e;

  // what decode receives for each instruction.
  typedef struct packed {
    inst_t inst;
    addr_t pc;
  } fetch_out_t;

endpackage

//--- verilog/pc_gen.sv
`timescale 1ns/10ps

module pc_gen #(
  parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             retire_i,
  input  logic             redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,

  input  logic             pc_take_i,
  output fetch_pkg::addr_t pc_o,
  output logic             pc_valid_o
);
  import fetch_pkg::*;

  addr_t pc_q;
  addr_t pc_seq;
  addr_t pc_target;
  logic  pc_valid_q;

  assign pc_seq = pc_q + 32'd4;
  // targets are word aligned, low bits are ignored.
  assign pc_target = {redirect_pc_i[31:WORD_OFF_W], {WORD_OFF_W{1'b0}}};

  assign pc_o = pc_q;
  assign pc_valid_o = pc_valid_q;

  // pc moves only on retire, so the taken pc stays put until decode accepts it.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
      pc_valid_q <= 1'b1;
    end
    else if (retire_i)
    begin
      pc_q <= redirect_i ? pc_target : pc_seq; // redirect only counts on retire.
      pc_valid_q <= 1'b1;
    end
    else if (pc_take_i)
    begin
      pc_valid_q <= 1'b0; // handed to ifu.
    end
  end

endmodule

//--- verilog/l1i_cache.sv
`timescale 1ns/10ps

module l1i_cache #(
  parameter int unsigned L1I_LINES = 8
) (
  input  logic             clk,
  input  logic             rst,

  input  fetch_pkg::addr_t lookup_addr_i,
  output logic             hit_o,
  output fetch_pkg::inst_t hit_data_o,

  input  logic             fill_en_i,
  input  fetch_pkg::addr_t fill_addr_i,
  input  fetch_pkg::inst_t fill_data_i,

  input  logic             flush_i
);
  import fetch_pkg::*;

  localparam int unsigned ADDR_W = $bits(addr_t);
  localparam int unsigned IDX_W  = $clog2(L1I_LINES);
  localparam int unsigned TAG_W  = ADDR_W - IDX_W - WORD_OFF_W;

  // one word per line.
  inst_t                data_mem [L1I_LINES];
  logic [TAG_W-1:0]     tag_mem  [L1I_LINES];
  logic [L1I_LINES-1:0] valid_q;

  logic [IDX_W-1:0] lk_idx;
  logic [TAG_W-1:0] lk_tag;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;

  logic  hit_q;
  inst_t data_q;

  // address split: tag | index | word offset.
  assign lk_idx   = lookup_addr_i[WORD_OFF_W +: IDX_W];
  assign lk_tag   = lookup_addr_i[ADDR_W-1 -: TAG_W];
  assign fill_idx = fill_addr_i[WORD_OFF_W +: IDX_W];
  assign fill_tag = fill_addr_i[ADDR_W-1 -: TAG_W];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0; // fence.i, drops the line filled this cycle too.
    end
    else if (fill_en_i)
    begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_en_i)
    begin
      data_mem[fill_idx] <= fill_data_i;
      tag_mem[fill_idx] <= fill_tag;
    end
  end

  // registered lookup, result is seen one cycle after the address.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hit_q <= 1'b0;
    end
    else
    begin
      hit_q <= valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    end
  end

  always_ff @(posedge clk)
  begin
    data_q <= data_mem[lk_idx];
  end

  assign hit_o = hit_q;
  assign hit_data_o = data_q;

endmodule

//--- verilog/ifu.sv
`timescale 1ns/10ps

module ifu #(
  parameter int unsigned L1I_LINES = 8
) (
  input  logic                 clk,
  input  logic                 rst,

  // pc_gen side.
  input  fetch_pkg::addr_t     pc_i,
  input  logic                 pc_valid_i,
  output logic                 pc_take_o,
  output logic                 retire_o,

  // cache side.
  output fetch_pkg::addr_t     lookup_addr_o,
  output fetch_pkg::addr_t     fill_addr_o,
  output logic                 fill_en_o,
  output logic                 flush_o,
  output fetch_pkg::inst_t     fill_data_o,
  input  logic                 hit_i,
  input  fetch_pkg::inst_t     hit_data_i,

  // read bus.
  output fetch_pkg::addr_t     bus_araddr_o,
  output logic                 bus_arvalid_o,
  input  fetch_pkg::inst_t     bus_rdata_i,
  input  logic                 bus_rvalid_i,

  // decode side.
  output logic                 fetch_valid_o,
  output fetch_pkg::fetch_out_t fetch_o,
  input  logic                 fetch_ready_i
);
  import fetch_pkg::*;

  bus_state_e state_q;
  bus_state_e state_d;

  addr_t      pc_q;
  fetch_out_t fetch_q;
  logic       fetch_valid_q;
  logic       arvalid_q;

  logic       take;
  logic       word_done;
  inst_t      word_in;

  assign take = (state_q == IDLE) && pc_valid_i;

  // a word is ready from either the cache or the bus.
  assign word_done = ((state_q == LOOKUP) && hit_i) ||
                     ((state_q == BUS_WAIT) && bus_rvalid_i);
  assign word_in = (state_q == LOOKUP) ? hit_data_i : bus_rdata_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (take) state_d = LOOKUP;
      LOOKUP:   state_d = hit_i ? HOLD : BUS_WAIT;
      BUS_WAIT: if (bus_rvalid_i) state_d = HOLD;
      HOLD:     if (fetch_ready_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      fetch_valid_q <= 1'b0;
      arvalid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (word_done)
        fetch_valid_q <= 1'b1;
      else if (retire_o)
        fetch_valid_q <= 1'b0;
      if ((state_q == LOOKUP) && !hit_i)
        arvalid_q <= 1'b1; // one request per miss.
      else if (fill_en_o)
        arvalid_q <= 1'b0; // drops the cycle after the data pulse.
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      pc_q <= pc_i;
    if (word_done)
    begin
      fetch_q.inst <= word_in;
      fetch_q.pc <= pc_q;
    end
  end

  assign pc_take_o = take;
  assign retire_o = fetch_valid_q && fetch_ready_i;

  // the taken pc is on pc_i in IDLE and lives in pc_q afterwards.
  assign lookup_addr_o = take ? pc_i : pc_q;
  assign fill_en_o = (state_q == BUS_WAIT) && bus_rvalid_i;
  assign fill_addr_o = pc_q;
  assign fill_data_o = bus_rdata_i;
  assign flush_o = word_done && (word_in == FENCE_I_INST);

  assign bus_araddr_o = pc_q;
  assign bus_arvalid_o = arvalid_q;

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_o = fetch_q;

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/10ps

module fetch_top #(
  parameter int unsigned      L1I_LINES = 8,
  parameter fetch_pkg::addr_t RESET_PC  = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  rst,

  // decode side.
  output logic                  fetch_valid_o,
  output fetch_pkg::fetch_out_t fetch_o,
  input  logic                  fetch_ready_i,
  input  logic                  redirect_i,
  input  fetch_pkg::addr_t      redirect_pc_i,

  // read bus.
  output fetch_pkg::addr_t      bus_araddr_o,
  output logic                  bus_arvalid_o,
  input  fetch_pkg::inst_t      bus_rdata_i,
  input  logic                  bus_rvalid_i
);
  import fetch_pkg::*;

  addr_t pc;
  logic  pc_valid;
  logic  pc_take;
  logic  retire;

  addr_t lookup_addr;
  addr_t fill_addr;
  logic  fill_en;
  inst_t fill_data;
  logic  flush;
  logic  hit;
  inst_t hit_data;

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .retire_i      (retire),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_take_i     (pc_take),
    .pc_o          (pc),
    .pc_valid_o    (pc_valid)
  );

  ifu #(
    .L1I_LINES (L1I_LINES)
  ) u_ifu (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc),
    .pc_valid_i    (pc_valid),
    .pc_take_o     (pc_take),
    .retire_o      (retire),
    .lookup_addr_o (lookup_addr),
    .fill_addr_o   (fill_addr),
    .fill_en_o     (fill_en),
    .flush_o       (flush),
    .fill_data_o   (fill_data),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .bus_araddr_o  (bus_araddr_o),
    .bus_arvalid_o (bus_arvalid_o),
    .bus_rdata_i   (bus_rdata_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_o       (fetch_o),
    .fetch_ready_i (fetch_ready_i)
  );

  l1i_cache #(
    .L1I_LINES (L1I_LINES)
  ) u_l1i_cache (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .hit_o         (hit),
    .hit_data_o    (hit_data),
    .fill_en_i     (fill_en),
    .fill_addr_i   (fill_addr),
    .fill_data_i   (fill_data),
    .flush_i       (flush)
  );

endmodule

//--- verif/fetch_mem_model.sv
`timescale 1ns/10ps

module fetch_mem_model #(
  parameter fetch_pkg::addr_t BASE  = 32'h0000_1000,
  parameter int unsigned      WORDS = 1024,
  parameter int               SEED  = 56
) (
  input  logic             clk,
  input  logic             rst,
  input  fetch_pkg::addr_t araddr_i,
  input  logic             arvalid_i,
  output fetch_pkg::inst_t rdata_o,
  output logic             rvalid_o
);
  import fetch_pkg::*;

  inst_t       mem [WORDS];
  integer      seed;
  logic        busy;
  int unsigned wait_cnt;

  // every address bit lands somewhere in the word.
  function automatic inst_t fill_word(input addr_t addr);
    fill_word = {addr[15:0] ^ 16'h5a3c, addr[31:16] ^ 16'h0013};
  endfunction

  function automatic logic in_window(input addr_t addr);
    in_window = (addr >= BASE) && (addr < BASE + WORDS * 4);
  endfunction

  function automatic inst_t read_word(input addr_t addr);
    if (in_window(addr))
      read_word = mem[(addr - BASE) >> 2];
    else
      read_word = fill_word(addr); // outside the window, pattern only.
  endfunction

  task automatic write_word(input addr_t addr, input inst_t data);
    if (in_window(addr))
      mem[(addr - BASE) >> 2] = data;
  endtask

  initial
  begin
    seed = SEED;
    busy = 1'b0;
    wait_cnt = 0;
    rvalid_o = 1'b0;
    rdata_o = '0;
    for (int i = 0; i < WORDS; i++)
      mem[i] = fill_word(BASE + 4 * i);
  end

  always @(negedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      rvalid_o <= 1'b0;
    end
    else if (rvalid_o)
    begin
      busy <= 1'b0;
      rvalid_o <= 1'b0; // one-cycle data pulse.
    end
    else if (busy)
    begin
      if (wait_cnt == 0)
      begin
        rvalid_o <= 1'b1;
        rdata_o <= read_word(araddr_i);
      end
      else
        wait_cnt <= wait_cnt - 1;
    end
    else if (arvalid_i)
    begin
      busy <= 1'b1;
      wait_cnt <= {$random(seed)} % 5; // answer 1 to 5 cycles later.
    end
  end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int unsigned L1I_LINES = 8;
  localparam addr_t       RESET_PC  = 32'h0000_1000;
  localparam addr_t       WIN_BASE  = 32'h0000_1000;
  localparam int unsigned WIN_WORDS = 1024;
  localparam int unsigned IDX_W     = $clog2(L1I_LINES);

  localparam addr_t LOOP_BASE = 32'h0000_1200;
  localparam addr_t STALE_PC  = 32'h0000_1300;
  localparam addr_t FENCE_PC  = 32'h0000_1344; // other index than STALE_PC.
  localparam addr_t CONF_A    = 32'h0000_1400;
  localparam addr_t CONF_B    = CONF_A + 4 * L1I_LINES; // same index, next tag.
  localparam addr_t BP_BASE   = 32'h0000_1500;
  localparam inst_t NEW_WORD  = 32'h00a0_0093;

  localparam int unsigned TOTAL_RETIRES = 64 + 31 + 5 + 10 + 40 + 500;

  logic       clk;
  logic       rst;
  logic       fetch_valid;
  fetch_out_t fetch_out;
  logic       fetch_ready;
  logic       redirect;
  addr_t      redirect_pc;
  addr_t      bus_araddr;
  logic       bus_arvalid;
  inst_t      bus_rdata;
  logic       bus_rvalid;

  integer      seed;
  int unsigned checks;
  int unsigned errors;
  int unsigned err_mark;
  int unsigned retires;

  // reference model of pc flow and cache contents.
  addr_t                exp_pc;
  logic [L1I_LINES-1:0] m_valid;
  addr_t                m_tag  [L1I_LINES];
  inst_t                m_data [L1I_LINES];
  int unsigned          exp_reads;
  int unsigned          bus_reads;
  fetch_out_t           held;

  logic        arvalid_prev;
  addr_t       araddr_prev;
  int unsigned reads_mark;
  inst_t       old_word;
  logic        redir;
  addr_t       target;

  fetch_top #(
    .L1I_LINES (L1I_LINES),
    .RESET_PC  (RESET_PC)
  ) u_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_o (fetch_valid),
    .fetch_o       (fetch_out),
    .fetch_ready_i (fetch_ready),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .bus_araddr_o  (bus_araddr),
    .bus_arvalid_o (bus_arvalid),
    .bus_rdata_i   (bus_rdata),
    .bus_rvalid_i  (bus_rvalid)
  );

  fetch_mem_model #(
    .BASE  (WIN_BASE),
    .WORDS (WIN_WORDS),
    .SEED  (56)
  ) u_mem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (bus_araddr),
    .arvalid_i (bus_arvalid),
    .rdata_o   (bus_rdata),
    .rvalid_o  (bus_rvalid)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("FAILED %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // waits for the next instruction and checks it against the model.
  task automatic wait_fetch();
    int unsigned idx;
    addr_t       tag;
    inst_t       exp_word;
    while (!fetch_valid)
    begin
      fetch_ready = $random(seed); // no effect while nothing is presented.
      redirect = $random(seed);
      redirect_pc = $random(seed);
      @(negedge clk);
    end
    idx = (exp_pc >> 2) % L1I_LINES;
    tag = exp_pc >> (IDX_W + 2);
    if (m_valid[idx] && (m_tag[idx] == tag))
      exp_word = m_data[idx];
    else
    begin
      exp_word = u_mem.read_word(exp_pc); // a miss fills the line from memory.
      exp_reads++;
      m_valid[idx] = 1'b1;
      m_tag[idx] = tag;
      m_data[idx] = exp_word;
    end
    if (exp_word == FENCE_I_INST)
      m_valid = '0;
    check_value("fetch_o.pc", exp_pc, fetch_out.pc);
    check_value("fetch_o.inst", exp_word, fetch_out.inst);
    check_value("bus read count", exp_reads, bus_reads);
    held.pc = exp_pc;
    held.inst = exp_word;
  endtask

  // holds ready low for up to stall_max cycles and then retires.
  task automatic retire_fetch(input logic redir_i, input addr_t target_i,
                              input int unsigned stall_max);
    int unsigned stalls;
    stalls = {$random(seed)} % (stall_max + 1);
    repeat (stalls)
    begin
      fetch_ready = 1'b0;
      redirect = $random(seed);
      redirect_pc = $random(seed);
      @(negedge clk);
      check_value("fetch_valid_o", 1, fetch_valid);
      check_value("fetch_o.pc held", held.pc, fetch_out.pc);
      check_value("fetch_o.inst held", held.inst, fetch_out.inst);
    end
    fetch_ready = 1'b1;
    redirect = redir_i;
    redirect_pc = redir_i ? target_i : addr_t'($random(seed));
    exp_pc = redir_i ? target_i : exp_pc + 4;
    retires++;
    @(negedge clk);
    fetch_ready = 1'b0;
    redirect = 1'b0;
  endtask

  task automatic fetch_step(input logic redir_i, input addr_t target_i,
                            input int unsigned stall_max);
    wait_fetch();
    retire_fetch(redir_i, target_i, stall_max);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  // counts bus requests and checks the address.
  always @(negedge clk)
  begin
    if (!rst && bus_arvalid)
    begin
      if (!arvalid_prev)
      begin
        bus_reads++;
        check_value("bus_araddr_o", exp_pc, bus_araddr);
      end
      else
        check_value("bus_araddr_o stable", araddr_prev, bus_araddr);
    end
    arvalid_prev = bus_arvalid;
    araddr_prev = bus_araddr;
  end

  initial
  begin
    repeat (TOTAL_RETIRES * 40) @(posedge clk);
    $display("watchdog expired after %0d retires, fetch stopped making progress", retires);
    $display("Regression failed");
    $finish;
  end

  initial
  begin
    seed = 56;
    rst = 1'b1;
    fetch_ready = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    checks = 0;
    errors = 0;
    err_mark = 0;
    retires = 0;
    exp_pc = RESET_PC;
    m_valid = '0;
    exp_reads = 0;
    bus_reads = 0;
    arvalid_prev = 1'b0;
    araddr_prev = '0;
    repeat (3) @(negedge clk);
    check_value("fetch_valid_o", 0, fetch_valid);
    check_value("bus_arvalid_o", 0, bus_arvalid);
    rst = 1'b0;

    repeat (64) fetch_step(1'b0, '0, 0);
    report_test(1, "reset and sequential fetch");

    fetch_step(1'b1, LOOP_BASE, 0);
    for (int pass = 0; pass < 5; pass++)
    begin
      if (pass == 1)
        reads_mark = bus_reads;
      for (int k = 0; k < 6; k++)
        fetch_step(k == 5, LOOP_BASE, 1);
    end
    check_value("bus reads in later loop passes", reads_mark, bus_reads);
    report_test(2, "loop hits in cache");

    u_mem.write_word(FENCE_PC, FENCE_I_INST);
    fetch_step(1'b1, STALE_PC, 0);
    old_word = u_mem.read_word(STALE_PC);
    wait_fetch();
    u_mem.write_word(STALE_PC, NEW_WORD);
    retire_fetch(1'b1, STALE_PC, 0);
    wait_fetch();
    check_value("fetch_o.inst stale", old_word, fetch_out.inst);
    retire_fetch(1'b1, FENCE_PC, 0);
    fetch_step(1'b1, STALE_PC, 0);
    reads_mark = bus_reads;
    wait_fetch();
    check_value("fetch_o.inst after fence.i", NEW_WORD, fetch_out.inst);
    check_value("bus reads after fence.i", reads_mark + 1, bus_reads);
    retire_fetch(1'b1, CONF_A, 0);
    report_test(3, "stale data then fence.i");

    reads_mark = bus_reads;
    for (int i = 0; i < 10; i++)
      fetch_step(1'b1, (i == 9) ? BP_BASE : ((i % 2 == 0) ? CONF_B : CONF_A), 0);
    check_value("bus reads for conflicting lines", reads_mark + 10, bus_reads);
    report_test(4, "conflict eviction");

    repeat (40) fetch_step(1'b0, '0, 3);
    report_test(5, "back-pressure");

    repeat (16)
    begin
      target = WIN_BASE + ({$random(seed)} % WIN_WORDS) * 4;
      u_mem.write_word(target, FENCE_I_INST);
    end
    repeat (500)
    begin
      redir = ({$random(seed)} % 4) == 0;
      target = WIN_BASE + ({$random(seed)} % WIN_WORDS) * 4;
      fetch_step(redir, target, 3);
    end
    check_value("total bus reads", exp_reads, bus_reads);
    report_test(6, "random mix");

    $display("tests 6, retires %0d, checks %0d, errors %0d", retires, checks, errors);
    if (errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/l1i_cache.sv
verilog/ifu.sv
verilog/fetch_top.sv
verif/fetch_mem_model.sv
verif/fetch_tb.sv
